/* design/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

// Width of the byte address on both the core and the bus side
`define LSU_ADDR_W 32

// Width of one data word and of the response payload union
`define LSU_DATA_W 32

////////////////////////////////////////////////////////////
// Outstanding transaction tracking
////////////////////////////////////////////////////////////

// Number of bus transactions allowed in flight at once
// Any value from 1 to 7 fits the counter below
`define LSU_MAX_OUTSTANDING 2

// Counter width must hold the limit itself
`define LSU_CNT_W 3

`endif

/* design/lsu_bus_pkg.sv */
`include "lsu_cfg.svh"

package lsu_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Request field types
  ////////////////////////////////////////////////////////////

  // Full byte address of a request
  typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

  // Write data and read data share one word type
  typedef logic [`LSU_DATA_W-1:0] lsu_data_t;

  // The two address bits below word granularity
  // These are the only bits that matter for the alignment check
  typedef logic [1:0] lsu_addr_lo_t;

  ////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////

  // Encoding follows the RISC-V funct3 size field of loads and stores
  // The value 2'b11 (doubleword) is not supported on this 32 bit path
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

endpackage

/* design/lsu_resp_pkg.sv */
`include "lsu_cfg.svh"

package lsu_resp_pkg;

  ////////////////////////////////////////////////////////////
  // Alignment checker state and status
  ////////////////////////////////////////////////////////////

  // The read and write flavours of the error are kept apart in the
  // state itself, so the kind survives the wait for outstanding traffic
  typedef enum logic [2:0] {
    ALIGN_IDLE        = 3'd0,
    ALIGN_WR_ERR_WAIT = 3'd1,
    ALIGN_RE_ERR_WAIT = 3'd2,
    ALIGN_WR_ERR_RESP = 3'd3,
    ALIGN_RE_ERR_RESP = 3'd4
  } align_state_e;

  // Status attached to every response towards the core
  typedef enum logic [1:0] {
    ALIGN_OK     = 2'b00,
    ALIGN_RE_ERR = 2'b01,
    ALIGN_WR_ERR = 2'b10
  } align_status_e;

  ////////////////////////////////////////////////////////////
  // Response payload
  ////////////////////////////////////////////////////////////

  // Error record padded to exactly one data word
  typedef struct packed {
    logic [`LSU_DATA_W-6:0]   pad;
    logic                     atomic;
    lsu_bus_pkg::lsu_size_e    size;
    lsu_bus_pkg::lsu_addr_lo_t addr_lo;
  } lsu_err_rec_t;

  // Read data on ALIGN_OK, error record on an error status
  typedef union packed {
    lsu_bus_pkg::lsu_data_t raw;
    lsu_err_rec_t           err;
  } lsu_resp_u;

endpackage

/* design/lsu_req_decode.sv */
`timescale 1ns/1ns

module lsu_req_decode (
  input  lsu_bus_pkg::lsu_addr_lo_t  addr_lo_i,
  input  lsu_bus_pkg::lsu_size_e     size_i,
  input  logic                       we_i,
  input  logic                       atomic_i,
  output logic                       check_en_o,
  output logic                       misaligned_o,
  output logic                       trans_we_o,
  output lsu_resp_pkg::lsu_err_rec_t err_rec_o
);

  import lsu_bus_pkg::*;

  // Only atomics must be naturally aligned on this path
  // Ordinary loads and stores are split later, so they pass unchecked
  assign check_en_o = atomic_i;

  // Natural alignment per access size
  // A byte is always aligned, a halfword needs bit 0 clear,
  // a word needs both low bits clear
  always_comb begin
    case (size_i)
      SIZE_BYTE: misaligned_o = 1'b0;
      SIZE_HALF: misaligned_o = addr_lo_i[0];
      SIZE_WORD: misaligned_o = |addr_lo_i;
      // The unused size code counts as misaligned so an atomic with it traps
      default:   misaligned_o = 1'b1;
    endcase
  end

  // The write flag selects between a read error and a write error
  assign trans_we_o = we_i;

  // Error record shown to the core in place of read data
  // It is only latched when an error request is actually accepted
  assign err_rec_o.pad     = '0;
  assign err_rec_o.atomic  = atomic_i;
  assign err_rec_o.size    = size_i;
  assign err_rec_o.addr_lo = addr_lo_i;

endmodule

/* design/lsu_align_fsm.sv */
`timescale 1ns/1ns

module lsu_align_fsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        core_valid_i,
  input  logic                        check_en_i,
  input  logic                        misaligned_i,
  input  logic                        trans_we_i,
  input  logic                        err_wait_i,
  input  logic                        bus_ready_i,
  input  logic                        cnt_full_i,
  input  logic                        idle_next_i,
  output logic                        core_ready_o,
  output logic                        bus_valid_o,
  output logic                        align_err_o,
  output logic                        err_valid_o,
  output lsu_resp_pkg::align_status_e err_status_o,
  output logic                        err_capture_o
);

  import lsu_resp_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  logic         align_err;
  logic         block_core;
  logic         block_bus;
  logic         err_ready;

  // A request violates alignment only when the check applies to it
  assign align_err = check_en_i && misaligned_i;

  ////////////////////////////////////////////////////////////
  // Next state and blocking
  ////////////////////////////////////////////////////////////

  // A misaligned atomic is consumed here and never reaches the bus
  // In wait mode the FSM holds off new traffic until every earlier
  // transaction has answered, then returns a single error response
  always_comb begin
    state_n       = state_q;
    block_core    = 1'b0;
    block_bus     = 1'b0;
    err_ready     = 1'b0;
    err_valid_o   = 1'b0;
    err_status_o  = ALIGN_OK;
    err_capture_o = 1'b0;

    case (state_q)
      ALIGN_IDLE: begin
        if (core_valid_i && align_err) begin
          // Keep it off the bus but accept it towards the core
          block_bus = 1'b1;
          err_ready = 1'b1;
          if (err_wait_i) begin
            err_capture_o = 1'b1;
            // Skip the wait when nothing will be in flight next cycle
            if (trans_we_i) begin
              state_n = idle_next_i ? ALIGN_WR_ERR_RESP : ALIGN_WR_ERR_WAIT;
            end else begin
              state_n = idle_next_i ? ALIGN_RE_ERR_RESP : ALIGN_RE_ERR_WAIT;
            end
          end
        end
      end

      ALIGN_WR_ERR_WAIT,
      ALIGN_RE_ERR_WAIT: begin
        block_core = 1'b1;
        block_bus  = 1'b1;
        // The last outstanding response arrives in this cycle
        if (idle_next_i) begin
          state_n = (state_q == ALIGN_WR_ERR_WAIT) ? ALIGN_WR_ERR_RESP : ALIGN_RE_ERR_RESP;
        end
      end

      ALIGN_WR_ERR_RESP,
      ALIGN_RE_ERR_RESP: begin
        block_core  = 1'b1;
        block_bus   = 1'b1;
        err_valid_o = 1'b1;
        err_status_o = (state_q == ALIGN_WR_ERR_RESP) ? ALIGN_WR_ERR : ALIGN_RE_ERR;
        // The core never stalls a response, so one cycle is enough
        state_n = ALIGN_IDLE;
      end

      default: begin
        state_n = ALIGN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGN_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake outputs
  ////////////////////////////////////////////////////////////

  // A full outstanding counter stalls good requests as well
  assign bus_valid_o  = core_valid_i && !block_bus && !cnt_full_i;
  assign core_ready_o = (bus_ready_i && !block_core && !cnt_full_i) || err_ready;

  // Immediate report raised whenever a bad request is presented
  assign align_err_o = core_valid_i && align_err;

  // The error response never takes two cycles, even across a wait
  a_resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q inside {ALIGN_WR_ERR_RESP, ALIGN_RE_ERR_RESP}) |=> (state_q == ALIGN_IDLE));

  // No request may leak to the bus while an error is pending
  a_no_bus_outside_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != ALIGN_IDLE) |-> !bus_valid_o);

endmodule

/* design/lsu_outstanding_cnt.sv */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_outstanding_cnt (
  input  logic clk,
  input  logic rst_n,
  input  logic bus_fire_i,
  input  logic bus_rvalid_i,
  output logic full_o,
  output logic idle_next_o
);

  localparam logic [`LSU_CNT_W-1:0] MAX_CNT = `LSU_MAX_OUTSTANDING;

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_n;

  // Accepted bus transfers count up, responses count down
  // A transfer and a response in the same cycle cancel out
  always_comb begin
    case ({bus_fire_i, bus_rvalid_i})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Full holds back new requests until something answers
  assign full_o = (cnt_q == MAX_CNT);

  // Nothing in flight from the next cycle on
  assign idle_next_o = (cnt_n == '0);

  a_no_inc_at_full: assert property (@(posedge clk) disable iff (!rst_n)
    full_o |-> !bus_fire_i);

  a_no_dec_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == '0) |-> !bus_rvalid_i);

endmodule

/* design/lsu_resp_merge.sv */
`timescale 1ns/1ns

module lsu_resp_merge (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        bus_rvalid_i,
  input  lsu_bus_pkg::lsu_data_t      bus_rdata_i,
  input  logic                        err_capture_i,
  input  lsu_resp_pkg::lsu_err_rec_t  err_rec_i,
  input  logic                        err_valid_i,
  input  lsu_resp_pkg::align_status_e err_status_i,
  output logic                        core_rvalid_o,
  output lsu_resp_pkg::lsu_resp_u     core_rdata_o,
  output lsu_resp_pkg::align_status_e core_status_o
);

  import lsu_resp_pkg::*;

  lsu_err_rec_t err_rec_q;

  // Hold the record of the consumed request until its response goes out
  // The core may already present a new request by then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_rec_q <= '0;
    end else if (err_capture_i) begin
      err_rec_q <= err_rec_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response selection
  ////////////////////////////////////////////////////////////

  assign core_rvalid_o = bus_rvalid_i || err_valid_i;

  // The same payload word carries read data or the error record
  always_comb begin
    if (err_valid_i) begin
      core_rdata_o.err = err_rec_q;
      core_status_o    = err_status_i;
    end else begin
      core_rdata_o.raw = bus_rdata_i;
      core_status_o    = ALIGN_OK;
    end
  end

  // The FSM only responds once the bus has gone quiet
  a_no_resp_collision: assert property (@(posedge clk) disable iff (!rst_n)
    err_valid_i |-> !bus_rvalid_i);

endmodule

/* design/lsu_align_top.sv */
`timescale 1ns/1ns

module lsu_align_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // Core request channel
  input  logic                        core_valid_i,
  output logic                        core_ready_o,
  input  lsu_bus_pkg::lsu_addr_t      core_addr_i,
  input  lsu_bus_pkg::lsu_size_e      core_size_i,
  input  logic                        core_we_i,
  input  logic                        core_atomic_i,
  input  lsu_bus_pkg::lsu_data_t      core_wdata_i,
  // Core response
  output logic                        core_rvalid_o,
  output lsu_resp_pkg::lsu_resp_u     core_rdata_o,
  output lsu_resp_pkg::align_status_e core_status_o,
  // Error reporting mode and immediate flag
  input  logic                        core_err_wait_i,
  output logic                        core_align_err_o,
  // Bus request channel
  output logic                        bus_valid_o,
  input  logic                        bus_ready_i,
  output lsu_bus_pkg::lsu_addr_t      bus_addr_o,
  output lsu_bus_pkg::lsu_size_e      bus_size_o,
  output logic                        bus_we_o,
  output lsu_bus_pkg::lsu_data_t      bus_wdata_o,
  // Bus response
  input  logic                        bus_rvalid_i,
  input  lsu_bus_pkg::lsu_data_t      bus_rdata_i
);

  import lsu_resp_pkg::*;

  logic          check_en;
  logic          misaligned;
  logic          trans_we;
  lsu_err_rec_t  err_rec;
  logic          cnt_full;
  logic          idle_next;
  logic          err_valid;
  align_status_e err_status;
  logic          err_capture;
  logic          bus_fire;

  // Requests travel unchanged, only valid is gated
  assign bus_addr_o  = core_addr_i;
  assign bus_size_o  = core_size_i;
  assign bus_we_o    = core_we_i;
  assign bus_wdata_o = core_wdata_i;

  assign bus_fire = bus_valid_o && bus_ready_i;

  lsu_req_decode u_decode (
    .addr_lo_i    (core_addr_i[1:0]),
    .size_i       (core_size_i),
    .we_i         (core_we_i),
    .atomic_i     (core_atomic_i),
    .check_en_o   (check_en),
    .misaligned_o (misaligned),
    .trans_we_o   (trans_we),
    .err_rec_o    (err_rec)
  );

  lsu_align_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_valid_i  (core_valid_i),
    .check_en_i    (check_en),
    .misaligned_i  (misaligned),
    .trans_we_i    (trans_we),
    .err_wait_i    (core_err_wait_i),
    .bus_ready_i   (bus_ready_i),
    .cnt_full_i    (cnt_full),
    .idle_next_i   (idle_next),
    .core_ready_o  (core_ready_o),
    .bus_valid_o   (bus_valid_o),
    .align_err_o   (core_align_err_o),
    .err_valid_o   (err_valid),
    .err_status_o  (err_status),
    .err_capture_o (err_capture)
  );

  lsu_outstanding_cnt u_cnt (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_fire_i   (bus_fire),
    .bus_rvalid_i (bus_rvalid_i),
    .full_o       (cnt_full),
    .idle_next_o  (idle_next)
  );

  lsu_resp_merge u_merge (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .err_capture_i (err_capture),
    .err_rec_i     (err_rec),
    .err_valid_i   (err_valid),
    .err_status_i  (err_status),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_status_o (core_status_o)
  );

endmodule

/* testbench/tb_lsu_align.sv */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module tb_lsu_align;

  import lsu_bus_pkg::*;
  import lsu_resp_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int MAX_OUT         = `LSU_MAX_OUTSTANDING;
  // Six directed tests with a generous budget of cycles each
  localparam int WATCHDOG_CYCLES = 6 * 200;

  logic          clk;
  logic          rst_n;
  logic          core_valid_i;
  logic          core_ready_o;
  lsu_addr_t     core_addr_i;
  lsu_size_e     core_size_i;
  logic          core_we_i;
  logic          core_atomic_i;
  lsu_data_t     core_wdata_i;
  logic          core_rvalid_o;
  lsu_resp_u     core_rdata_o;
  align_status_e core_status_o;
  logic          core_err_wait_i;
  logic          core_align_err_o;
  logic          bus_valid_o;
  logic          bus_ready_i;
  lsu_addr_t     bus_addr_o;
  lsu_size_e     bus_size_o;
  logic          bus_we_o;
  lsu_data_t     bus_wdata_o;
  logic          bus_rvalid_i;
  lsu_data_t     bus_rdata_i;

  integer        seed = 29;
  int            cyc = 0;
  int            fire_cnt = 0;
  bit            stall_rsp = 1'b0;
  lsu_data_t     mem [0:15];
  // Bus transactions accepted by the responder and not yet answered
  lsu_addr_t     pend_addr_q[$];
  logic          pend_we_q[$];
  lsu_data_t     pend_wdata_q[$];
  int            pend_due_q[$];
  // Every response seen by the core in arrival order
  lsu_resp_u     rsp_data_q[$];
  align_status_e rsp_stat_q[$];
  int            rsp_cyc_q[$];

  lsu_align_top UUT (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Memory contents before any write follow from the word's byte address
  function automatic lsu_data_t fill_word(input int idx);
    lsu_addr_t word_addr;
    word_addr = idx << 2;
    return 32'h5A00_0000 ^ (word_addr * 32'h0001_0103);
  endfunction

  function automatic lsu_resp_u data_resp(input lsu_data_t d);
    lsu_resp_u r;
    r.raw = d;
    return r;
  endfunction

  // Error record as the core should see it for a consumed atomic
  function automatic lsu_resp_u err_resp(input lsu_addr_lo_t lo, input lsu_size_e size);
    lsu_resp_u r;
    r.err.pad     = '0;
    r.err.atomic  = 1'b1;
    r.err.size    = size;
    r.err.addr_lo = lo;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus memory responder and response monitor
  ////////////////////////////////////////////////////////////

  // Answers in order one to four cycles after the transfer
  // Drives 1 ns after the edge, ahead of the core side, so stall_rsp
  // changes from the tests always take effect in the following cycle
  initial begin
    bus_ready_i  = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #1;
      bus_rvalid_i = 1'b0;
      bus_rdata_i  = '0;
      bus_ready_i  = rst_n && (($random(seed) & 3) != 0);
      if (rst_n && !stall_rsp && pend_due_q.size() > 0 && cyc >= pend_due_q[0]) begin
        bus_rvalid_i = 1'b1;
        // Writes answer with zero data
        if (pend_we_q[0]) begin
          mem[pend_addr_q[0][5:2]] = pend_wdata_q[0];
        end else begin
          bus_rdata_i = mem[pend_addr_q[0][5:2]];
        end
        void'(pend_addr_q.pop_front());
        void'(pend_we_q.pop_front());
        void'(pend_wdata_q.pop_front());
        void'(pend_due_q.pop_front());
      end
    end
  end

  // Sampling at the falling edge sees settled DUT outputs
  always @(negedge clk) begin
    if (rst_n && core_rvalid_o) begin
      rsp_data_q.push_back(core_rdata_o);
      rsp_stat_q.push_back(core_status_o);
      rsp_cyc_q.push_back(cyc);
    end
    if (rst_n && bus_valid_o && bus_ready_i) begin
      fire_cnt = fire_cnt + 1;
      pend_addr_q.push_back(bus_addr_o);
      pend_we_q.push_back(bus_we_o);
      pend_wdata_q.push_back(bus_wdata_o);
      pend_due_q.push_back(cyc + 1 + ($random(seed) & 3));
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got %b, expected %b", msg, got, exp));
    end
  endtask

  task automatic check_status(input align_status_e got, input align_status_e exp,
                              input string msg);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: status %s, expected %s", msg, got.name(), exp.name()));
    end
  endtask

  // The union is compared through the view that its status selects
  task automatic check_resp(input lsu_resp_u got, input lsu_resp_u exp, input bit err_view,
                            input string msg);
    if (err_view && got.err !== exp.err) begin
      report_mismatch($sformatf("%s: record lo=%b size=%b atomic=%b, expected lo=%b size=%b",
                                msg, got.err.addr_lo, got.err.size, got.err.atomic,
                                exp.err.addr_lo, exp.err.size));
    end else if (!err_view && got.raw !== exp.raw) begin
      report_mismatch($sformatf("%s: data %h, expected %h", msg, got.raw, exp.raw));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Holds one request until accepted and checks what reaches the bus
  task automatic send_req(input lsu_addr_t addr, input lsu_size_e size, input logic we,
                          input logic atomic, input lsu_data_t wdata, input logic exp_err,
                          output int acc_cyc, output int waits);
    logic accepted;
    accepted      = 1'b0;
    waits         = 0;
    core_valid_i  = 1'b1;
    core_addr_i   = addr;
    core_size_i   = size;
    core_we_i     = we;
    core_atomic_i = atomic;
    core_wdata_i  = wdata;
    while (!accepted) begin
      @(negedge clk);
      check_flag(core_align_err_o, exp_err, "immediate alignment error flag");
      if (exp_err) begin
        check_flag(bus_valid_o, 1'b0, "bus valid for a misaligned atomic");
      end
      if (bus_valid_o) begin
        check_flag(bus_addr_o == addr && bus_size_o == size && bus_we_o == we &&
                   bus_wdata_o == wdata, 1'b1, "bus request equals core request");
      end
      accepted = core_ready_o;
      acc_cyc  = cyc;
      if (!accepted) begin
        waits = waits + 1;
      end
      @(posedge clk);
      #2;
    end
    core_valid_i = 1'b0;
  endtask

  task automatic next_resp(input align_status_e exp_stat, input lsu_resp_u exp_data,
                           input bit err_view, input string msg, output int rsp_cyc);
    while (rsp_stat_q.size() == 0) begin
      @(posedge clk);
      #2;
    end
    check_status(rsp_stat_q.pop_front(), exp_stat, msg);
    check_resp(rsp_data_q.pop_front(), exp_data, err_view, msg);
    rsp_cyc = rsp_cyc_q.pop_front();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_outputs_idle();
    @(negedge clk);
    check_flag(bus_valid_o, 1'b0, "bus valid after reset");
    check_flag(core_rvalid_o, 1'b0, "core response valid after reset");
    check_flag(core_align_err_o, 1'b0, "alignment error flag after reset");
    @(posedge clk);
    #2;
  endtask

  task automatic pass_through_traffic();
    int acc;
    int w;
    int rc;
    send_req(32'h08, SIZE_WORD, 1'b1, 1'b0, 32'hCAFE_0001, 1'b0, acc, w);
    send_req(32'h08, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, acc, w);
    send_req(32'h04, SIZE_HALF, 1'b0, 1'b0, '0, 1'b0, acc, w);
    // Misaligned but not atomic, so it goes out untouched
    send_req(32'h05, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, acc, w);
    next_resp(ALIGN_OK, data_resp('0), 1'b0, "write response", rc);
    next_resp(ALIGN_OK, data_resp(32'hCAFE_0001), 1'b0, "read after write", rc);
    next_resp(ALIGN_OK, data_resp(fill_word(1)), 1'b0, "halfword read", rc);
    next_resp(ALIGN_OK, data_resp(fill_word(1)), 1'b0, "offset word read", rc);
  endtask

  task automatic atomic_error_alone();
    int f0;
    int acc;
    int w;
    int rc;
    f0 = fire_cnt;
    send_req(32'h13, SIZE_WORD, 1'b0, 1'b1, '0, 1'b1, acc, w);
    next_resp(ALIGN_RE_ERR, err_resp(2'b11, SIZE_WORD), 1'b1, "atomic read error", rc);
    check_flag(rc == acc + 1, 1'b1, "error response one cycle after acceptance");
    check_flag(fire_cnt == f0, 1'b1, "no bus transfer for the atomic");
  endtask

  task automatic atomic_error_after_reads();
    int f0;
    int a_err;
    int a_new;
    int w;
    int rc;
    int last_rc;
    int err_rc;
    // Read responses are held back so the error has to wait for them
    stall_rsp = 1'b1;
    send_req(32'h0C, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, a_new, w);
    send_req(32'h10, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, a_new, w);
    f0 = fire_cnt;
    send_req(32'h11, SIZE_HALF, 1'b1, 1'b1, 32'h1234_5678, 1'b1, a_err, w);
    stall_rsp = 1'b0;
    send_req(32'h14, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, a_new, w);
    next_resp(ALIGN_OK, data_resp(fill_word(3)), 1'b0, "first read", rc);
    next_resp(ALIGN_OK, data_resp(fill_word(4)), 1'b0, "second read", last_rc);
    next_resp(ALIGN_WR_ERR, err_resp(2'b01, SIZE_HALF), 1'b1, "atomic write error", err_rc);
    // The error follows the later of acceptance and the last read response
    check_flag(err_rc == ((a_err > last_rc) ? a_err : last_rc) + 1, 1'b1,
               "error response timing after outstanding reads");
    next_resp(ALIGN_OK, data_resp(fill_word(5)), 1'b0, "read after the error", rc);
    check_flag(a_new > err_rc, 1'b1, "new request held until the error response");
    check_flag(fire_cnt == f0 + 1, 1'b1, "only the new read reached the bus");
  endtask

  task automatic immediate_error_mode();
    int f0;
    int acc;
    int w;
    int rc;
    core_err_wait_i = 1'b0;
    f0 = fire_cnt;
    send_req(32'h22, SIZE_WORD, 1'b0, 1'b1, '0, 1'b1, acc, w);
    check_flag(w == 0, 1'b1, "error request accepted in one cycle");
    idle_cycles(5);
    check_flag(rsp_stat_q.size() == 0, 1'b1, "no response in immediate mode");
    check_flag(fire_cnt == f0, 1'b1, "no bus transfer in immediate mode");
    send_req(32'h18, SIZE_WORD, 1'b0, 1'b1, '0, 1'b0, acc, w);
    next_resp(ALIGN_OK, data_resp(fill_word(6)), 1'b0, "aligned atomic read", rc);
    core_err_wait_i = 1'b1;
  endtask

  task automatic outstanding_limit_stall();
    int acc;
    int w;
    int rc;
    int first_rc;
    logic accepted;
    stall_rsp = 1'b1;
    for (int n = 0; n < MAX_OUT; n++) begin
      send_req(32'h20 + 4 * n, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, acc, w);
    end
    core_valid_i  = 1'b1;
    core_addr_i   = 32'h3C;
    core_size_i   = SIZE_WORD;
    core_we_i     = 1'b0;
    core_atomic_i = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_flag(core_ready_o, 1'b0, "core ready at the outstanding limit");
      check_flag(bus_valid_o, 1'b0, "bus valid at the outstanding limit");
      @(posedge clk);
      #2;
    end
    stall_rsp = 1'b0;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = core_ready_o;
      acc      = cyc;
      @(posedge clk);
      #2;
    end
    core_valid_i = 1'b0;
    for (int n = 0; n < MAX_OUT; n++) begin
      next_resp(ALIGN_OK, data_resp(fill_word(8 + n)), 1'b0, "read at the limit", rc);
      if (n == 0) begin
        first_rc = rc;
      end
    end
    next_resp(ALIGN_OK, data_resp(fill_word(15)), 1'b0, "held read", rc);
    check_flag(acc > first_rc, 1'b1, "held read accepted after a response");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    core_valid_i    = 1'b0;
    core_addr_i     = '0;
    core_size_i     = SIZE_WORD;
    core_we_i       = 1'b0;
    core_atomic_i   = 1'b0;
    core_wdata_i    = '0;
    core_err_wait_i = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_outputs_idle();
    pass_through_traffic();
    atomic_error_alone();
    atomic_error_after_reads();
    immediate_error_mode();
    outstanding_limit_stall();
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* filelist.f */
+incdir+design
design/lsu_bus_pkg.sv
design/lsu_resp_pkg.sv
design/lsu_req_decode.sv
design/lsu_align_fsm.sv
design/lsu_outstanding_cnt.sv
design/lsu_resp_merge.sv
design/lsu_align_top.sv
testbench/tb_lsu_align.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_lsu_align -o tb_lsu_align > build.log 2>&1 &&
  ./obj_dir/tb_lsu_align > sim.log 2>&1 ||
  echo "build or simulation returned an error status"
cat build.log sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }
